/* dv/dma_tb.sv */
// DMA subsystem testbench
`default_nettype none

module dma_tb;
	import dma_bus_pkg::*;

	localparam addr_t PARK_ADDR = 16'h4015;  // CPU idles reading here while halted
	localparam int    CPU_CLKS  = 12;        // Master clocks per CPU cycle

	logic  clk, reset, cpu_rnw, dmc_req;
	logic  mem_read, mem_write, pause_cpu, cpu_ce, odd_cycle, dmc_ack;
	addr_t cpu_addr, dmc_addr, mem_addr;
	data_t cpu_dout, mem_rdata, mem_dout, dmc_data;

	int    errors = 0;
	int    checks = 0;
	int    dmc_count = 0;
	int    xfer_count = 0;
	logic  xfer_on = 1'b0;  // A sprite transfer is expected on the bus
	page_t spr_page;
	int    rd_idx;          // Next sprite read expected
	int    wr_idx;          // Next $2004 write expected
	int    ce_gap = 0;      // Clocks since the last cpu_ce
	logic  exp_odd = 1'b0;  // Parity the divider should show

	dma_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Memory contents, also the reference for every byte
	function automatic data_t mem_byte(input addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	assign mem_rdata = mem_byte(mem_addr);  // No wait states

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run;
		$display("Checks: %0d, errors: %0d, sprite transfers: %0d, DMC fetches: %0d",
			checks, errors, xfer_count, dmc_count);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	task automatic stop_on_timeout(input string what);
		errors++;
		$display("Timed out at %0t while waiting for %s", $time, what);
		finish_run();
	endtask

	// Ends at the next CPU cycle boundary, 5 units after the edge
	task automatic next_cycle;
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_ce && n < 64) begin
			@(negedge clk);
			n++;
		end
		if (cpu_ce) begin
			@(posedge clk);
			#5;
		end else
			stop_on_timeout("cpu_ce");
	endtask

	// One CPU bus cycle, then back to the parked read
	task automatic cpu_access(input addr_t a, input data_t d, input logic rnw);
		int n;
		n = 0;
		next_cycle();
		while (pause_cpu && n < 4000) begin  // Halted CPU holds off
			next_cycle();
			n++;
		end
		if (pause_cpu)
			stop_on_timeout("pause_cpu to clear before a CPU access");
		else begin
			cpu_addr = a;
			cpu_dout = d;
			cpu_rnw  = rnw;
			next_cycle();
			cpu_addr = PARK_ADDR;
			cpu_dout = 8'h00;
			cpu_rnw  = 1'b1;
		end
	endtask

	task automatic wait_pause_low;
		int n;
		n = 0;
		while (pause_cpu && n < 4000) begin
			next_cycle();
			n++;
		end
		if (pause_cpu)
			stop_on_timeout("pause_cpu to fall");
	endtask

	// Full four-phase DMC exchange from the agent side
	task automatic dmc_fetch(input addr_t a);
		int n;
		n = 0;
		next_cycle();
		dmc_addr = a;
		dmc_req  = 1'b1;
		while (!dmc_ack && n < 50) begin
			next_cycle();
			n++;
		end
		if (!dmc_ack)
			stop_on_timeout("dmc_ack to rise");
		else begin
			check_value("dmc_data", dmc_data, mem_byte(a));
			repeat (2) begin
				next_cycle();
				check_value("dmc_ack", dmc_ack, 1'b1);  // Held while req stays up
			end
			dmc_req = 1'b0;
			next_cycle();
			check_value("dmc_ack", dmc_ack, 1'b0);  // Drops on the next cpu_ce
			dmc_count++;
		end
	endtask

	task automatic sprite_transfer(input page_t page, input logic with_dmc);
		addr_t steal_addr;
		steal_addr = {~page, 8'($urandom)};  // High byte never matches the page
		spr_page = page;
		rd_idx   = 0;
		wr_idx   = 0;
		xfer_on  = 1'b1;
		cpu_access(SPRITE_TRIGGER_ADDR, page, 1'b0);
		check_value("pause_cpu", pause_cpu, 1'b1);
		fork
			wait_pause_low();
			if (with_dmc) begin
				repeat (100) next_cycle();  // Well inside the 512 cycle transfer
				dmc_fetch(steal_addr);
			end
		join
		xfer_on = 1'b0;
		check_value("sprite write count", 16'(wr_idx), 16'd256);
		check_value("sprite read count", 16'(rd_idx), 16'd256);
		xfer_count++;
	endtask

	// One cpu_ce every CPU_CLKS clocks and a parity flip on each
	always @(negedge clk) begin
		if (reset) begin
			ce_gap  = 0;
			exp_odd = 1'b0;
		end else begin
			ce_gap++;
			check_value("odd_cycle", odd_cycle, exp_odd);
			if (cpu_ce) begin
				check_value("cpu_ce period", 16'(ce_gap), 16'(CPU_CLKS));
				ce_gap  = 0;
				exp_odd = ~exp_odd;
			end
		end
	end

	// Bus compare at mid cycle once per CPU cycle
	always @(negedge clk) begin
		if (!reset && cpu_ce) begin
			if (!pause_cpu) begin  // CPU owns the bus
				check_value("mem_addr", mem_addr, cpu_addr);
				check_value("mem_dout", mem_dout, cpu_dout);
				check_value("mem_read", mem_read, cpu_rnw);
				check_value("mem_write", mem_write, !cpu_rnw);
			end
			if (xfer_on && mem_read && mem_addr[15:8] == spr_page) begin
				check_value("odd_cycle on sprite read", odd_cycle, 1'b0);
				check_value("sprite read mem_addr", mem_addr, {spr_page, 8'(rd_idx)});
				rd_idx++;
			end
			if (xfer_on && mem_write && mem_addr == OAM_DATA_ADDR) begin
				check_value("odd_cycle on sprite write", odd_cycle, 1'b1);
				assert (wr_idx < 256) else begin
					errors++;
					$display("Extra write to the sprite port at %0t after byte 255", $time);
				end
				check_value("sprite mem_dout", mem_dout, mem_byte({spr_page, 8'(wr_idx)}));
				wr_idx++;
			end
		end
	end

	initial begin
		addr_t a;
		logic  rnw;
		void'($urandom(32'h875fe95c));
		reset    = 1'b1;
		cpu_addr = PARK_ADDR;
		cpu_dout = 8'h00;
		cpu_rnw  = 1'b1;
		dmc_req  = 1'b0;
		dmc_addr = 16'h0000;
		repeat (10) @(posedge clk);
		#5 reset = 1'b0;
		check_value("pause_cpu", pause_cpu, 1'b0);
		check_value("dmc_ack", dmc_ack, 1'b0);
		check_value("mem_write", mem_write, 1'b0);
		repeat (24) begin  // Plain CPU traffic, DMA idle
			a   = 16'($urandom);
			rnw = 1'($urandom);
			if (!rnw && a == SPRITE_TRIGGER_ADDR)
				a = PARK_ADDR;
			cpu_access(a, 8'($urandom), rnw);
		end
		repeat (3) dmc_fetch(16'($urandom));
		sprite_transfer(8'($urandom_range(63, 0)), 1'b0);
		sprite_transfer(8'($urandom_range(63, 0)), 1'b1);  // DMC steals a cycle
		repeat (8) cpu_access(16'($urandom_range(16'h07FF, 0)), 8'($urandom), 1'b0);
		finish_run();
	end

endmodule

`default_nettype wire

/* source/cpu_bus_mux.sv */
// CPU and DMA bus multiplexer
`default_nettype none

module cpu_bus_mux (
	input  dma_bus_pkg::addr_t  cpu_addr,
	input  dma_bus_pkg::data_t  cpu_dout,
	input  logic                cpu_rnw,
	dma_bus_if.mux              dma,
	output logic                trigger,
	output dma_bus_pkg::page_t  page,
	output dma_bus_pkg::addr_t  mem_addr,
	output logic                mem_read,
	output logic                mem_write,
	output dma_bus_pkg::data_t  mem_dout
);
	import dma_bus_pkg::*;

	// CPU write to the sprite DMA register
	assign trigger = !dma.active && !cpu_rnw && (cpu_addr == SPRITE_TRIGGER_ADDR);
	assign page    = cpu_dout;  // Written byte names the page

	always_comb begin
		if (dma.active) begin
			mem_addr  = dma.addr;
			mem_read  = dma.read;
			mem_write = !dma.read;
			mem_dout  = dma.wdata;
		end else begin
			mem_addr  = cpu_addr;   // CPU owns the bus
			mem_read  = cpu_rnw;
			mem_write = !cpu_rnw;
			mem_dout  = cpu_dout;
		end
	end

endmodule

`default_nettype wire

/* source/cpu_cycle_gen.sv */
// CPU clock enable divider
`default_nettype none

module cpu_cycle_gen #(
	parameter dma_seq_pkg::div_cnt_t CPU_DIV = dma_seq_pkg::CPU_DIV_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic odd_cycle
);
	import dma_seq_pkg::*;

	div_cnt_t div_cnt;  // Master clocks into current CPU cycle

	// Last master clock of the CPU cycle
	assign cpu_ce = (div_cnt == CPU_DIV - 5'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= '0;
			odd_cycle <= 1'b0;  // First CPU cycle is even
		end else begin
			if (cpu_ce) begin
				div_cnt   <= '0;
				odd_cycle <= ~odd_cycle;
			end else begin
				div_cnt <= div_cnt + 5'd1;
			end
		end
	end

	// Every state machine steps once per pulse, a double pulse would skip a cycle
	ce_single_clk: assert property (
		@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce
	);

endmodule

`default_nettype wire

/* source/dma_bus_if.sv */
// DMA bus request interface
`default_nettype none

interface dma_bus_if;
	import dma_bus_pkg::*;

	addr_t addr;    // Address the DMA wants on the bus
	logic  active;  // DMA owns the bus this cycle
	logic  read;    // 1 = read, 0 = write
	data_t wdata;   // Byte for the sprite port

	// Engine side drives the request
	modport dma (
		output addr,
		output active,
		output read,
		output wdata
	);

	// Multiplexer only looks at it
	modport mux (
		input addr,
		input active,
		input read,
		input wdata
	);

endinterface

`default_nettype wire

/* source/dma_bus_pkg.sv */
// DMA bus types and addresses
`default_nettype none

package dma_bus_pkg;

	// CPU side address and data
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;

	typedef logic [7:0] page_t;  // High byte of sprite source

	// Writing a page number here starts sprite DMA
	localparam addr_t SPRITE_TRIGGER_ADDR = 16'h4014;

	// PPU sprite data port, every sprite byte goes here
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

endpackage

`default_nettype wire

/* source/dma_seq_pkg.sv */
// DMA sequencing types
`default_nettype none

package dma_seq_pkg;

	// Sprite engine states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		ALIGN = 2'd1,   // Waiting for an odd read cycle
		XFER  = 2'd2    // Read/write pairs running
	} spr_state_t;

	// DMC fetch states
	typedef enum logic [1:0] {
		WAIT_REQ  = 2'd0,
		WAIT_SLOT = 2'd1,
		READ      = 2'd2,   // Owns the even cycle
		HOLD_ACK  = 2'd3
	} dmc_state_t;

	typedef logic [4:0] div_cnt_t;
	localparam div_cnt_t CPU_DIV_DEFAULT = 5'd12;  // Master clocks per CPU cycle

endpackage

`default_nettype wire

/* source/dma_top.sv */
// DMA subsystem top
`default_nettype none

module dma_top #(
	parameter dma_seq_pkg::div_cnt_t CPU_DIV = dma_seq_pkg::CPU_DIV_DEFAULT
) (
	input  logic               clk,
	input  logic               reset,
	input  dma_bus_pkg::addr_t cpu_addr,
	input  dma_bus_pkg::data_t cpu_dout,
	input  logic               cpu_rnw,
	input  dma_bus_pkg::data_t mem_rdata,
	input  logic               dmc_req,
	input  dma_bus_pkg::addr_t dmc_addr,
	output dma_bus_pkg::addr_t mem_addr,
	output logic               mem_read,
	output logic               mem_write,
	output dma_bus_pkg::data_t mem_dout,
	output logic               pause_cpu,
	output logic               cpu_ce,
	output logic               odd_cycle,
	output logic               dmc_ack,
	output dma_bus_pkg::data_t dmc_data
);
	import dma_bus_pkg::*;

	logic  trigger;
	page_t page;
	logic  dmc_slot;
	logic  dmc_pending;
	logic  xfer_busy;

	dma_bus_if dma_bus ();

	cpu_cycle_gen #(
		.CPU_DIV (CPU_DIV)
	) u_cycle (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dmc_fetch_slot u_dmc (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.cpu_rnw     (cpu_rnw),
		.dmc_req     (dmc_req),
		.dmc_addr    (dmc_addr),
		.mem_rdata   (mem_rdata),
		.dmc_slot    (dmc_slot),
		.dmc_pending (dmc_pending),
		.dmc_ack     (dmc_ack),
		.dmc_data    (dmc_data)
	);

	sprite_dma_engine u_sprite (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.cpu_rnw   (cpu_rnw),
		.trigger   (trigger),
		.dmc_slot  (dmc_slot),
		.page      (page),
		.dmc_addr  (dmc_addr),
		.mem_rdata (mem_rdata),
		.bus       (dma_bus.dma),
		.xfer_busy (xfer_busy)
	);

	cpu_bus_mux u_mux (
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.cpu_rnw   (cpu_rnw),
		.dma       (dma_bus.mux),
		.trigger   (trigger),
		.page      (page),
		.mem_addr  (mem_addr),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_dout  (mem_dout)
	);

	assign pause_cpu = xfer_busy | dmc_pending;  // CPU waits for either DMA

endmodule

`default_nettype wire

/* source/dmc_fetch_slot.sv */
// DMC sample fetch slot
`default_nettype none

module dmc_fetch_slot (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               odd_cycle,
	input  logic               cpu_rnw,
	input  logic               dmc_req,
	input  dma_bus_pkg::addr_t dmc_addr,
	input  dma_bus_pkg::data_t mem_rdata,
	output logic               dmc_slot,
	output logic               dmc_pending,
	output logic               dmc_ack,
	output dma_bus_pkg::data_t dmc_data
);
	import dma_seq_pkg::*;

	dmc_state_t state;

	assign dmc_slot = (state == READ);  // Engine yields this even cycle

	// Pause the CPU from request until the byte is in hand
	always_comb begin
		case (state)
			WAIT_REQ:  dmc_pending = dmc_req;
			WAIT_SLOT: dmc_pending = 1'b1;
			READ:      dmc_pending = 1'b1;
			default:   dmc_pending = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= WAIT_REQ;
			dmc_ack <= 1'b0;
		end else if (cpu_ce) begin
			case (state)
				WAIT_REQ: begin
					// Only start on an even read cycle
					if (dmc_req && cpu_rnw && !odd_cycle)
						state <= WAIT_SLOT;
				end
				WAIT_SLOT: begin
					if (odd_cycle)
						state <= READ;  // Next cycle is even
				end
				READ: begin
					state   <= HOLD_ACK;
					dmc_ack <= 1'b1;
				end
				HOLD_ACK: begin
					if (!dmc_req) begin  // Four-phase return to zero
						state   <= WAIT_REQ;
						dmc_ack <= 1'b0;
					end
				end
				default: state <= WAIT_REQ;
			endcase
		end
	end

	// Sample byte, taken at the end of the stolen cycle
	always_ff @(posedge clk) begin
		if (cpu_ce && state == READ)
			dmc_data <= mem_rdata;
	end

	ack_in_hold: assert property (
		@(posedge clk) disable iff (reset)
		dmc_ack |-> state == HOLD_ACK
	);

	// Agent keeps the request up until answered
	req_held: assert property (
		@(posedge clk) disable iff (reset)
		$fell(dmc_req) |-> dmc_ack
	);

	// Address must not move while the fetch is outstanding
	addr_stable: assert property (
		@(posedge clk) disable iff (reset)
		dmc_req && !dmc_ack |=> !dmc_req || $stable(dmc_addr)
	);

endmodule

`default_nettype wire

/* source/sprite_dma_engine.sv */
// Sprite DMA engine
`default_nettype none

module sprite_dma_engine (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               odd_cycle,
	input  logic               cpu_rnw,
	input  logic               trigger,
	input  logic               dmc_slot,
	input  dma_bus_pkg::page_t page,
	input  dma_bus_pkg::addr_t dmc_addr,
	input  dma_bus_pkg::data_t mem_rdata,
	dma_bus_if.dma             bus,
	output logic               xfer_busy
);
	import dma_bus_pkg::*;
	import dma_seq_pkg::*;

	spr_state_t state;
	page_t      src_page;   // Source page from the $4014 write
	logic [7:0] idx;        // Low byte, one step per pair
	data_t      rd_latch;   // Byte between read and write

	logic even_read;  // Sprite read lands this cycle
	logic last_pair;

	assign even_read = (state == XFER) && !odd_cycle && !dmc_slot;
	assign last_pair = (idx == 8'hFF);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			idx   <= 8'h00;
		end else if (cpu_ce) begin
			case (state)
				IDLE: begin
					if (trigger) begin
						state <= ALIGN;
						idx   <= 8'h00;
					end
				end
				ALIGN: begin
					// Reads must fall on even cycles
					if (cpu_rnw && odd_cycle)
						state <= XFER;
				end
				XFER: begin
					if (!odd_cycle && dmc_slot) begin
						state <= ALIGN;  // DMC took the read, odd cycle goes idle
					end else if (odd_cycle) begin
						idx <= idx + 8'd1;  // Write done
						if (last_pair)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Page and read byte
	always_ff @(posedge clk) begin
		if (cpu_ce && state == IDLE && trigger)
			src_page <= page;
		if (cpu_ce && even_read)
			rd_latch <= mem_rdata;
	end

	assign xfer_busy = (state != IDLE);

	// DMC first, then sprite read, then sprite port write
	assign bus.active = dmc_slot || (state == XFER);
	assign bus.read   = dmc_slot || !odd_cycle;
	assign bus.wdata  = rd_latch;
	always_comb begin
		if (dmc_slot)
			bus.addr = dmc_addr;
		else if (!odd_cycle)
			bus.addr = {src_page, idx};
		else
			bus.addr = OAM_DATA_ADDR;
	end

	// Each sprite read is followed by its port write in the odd cycle
	write_after_read: assert property (
		@(posedge clk) disable iff (reset)
		cpu_ce && even_read |=> odd_cycle && bus.active && !bus.read
	);

endmodule

`default_nettype wire

/* sources.f */
source/dma_bus_pkg.sv
source/dma_seq_pkg.sv
source/dma_bus_if.sv
source/cpu_cycle_gen.sv
source/dmc_fetch_slot.sv
source/sprite_dma_engine.sv
source/cpu_bus_mux.sv
source/dma_top.sv
dv/dma_tb.sv
